// File: complex_pkg.sv
// Accelerator complex package with bus widths, word types and the default config window
package complex_pkg;

  // Data bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Peripheral port id width
  localparam int unsigned IdWidth = 8;

  // Bus word types
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;
  typedef logic [IdWidth-1:0]   id_t;

  // Accelerator configuration window, end is exclusive
  localparam addr_t DefCfgStart = 32'h0010_0000;
  localparam addr_t DefCfgEnd   = 32'h0010_0400;

  // Demux target, memory is the default
  typedef enum logic {
    TGT_MEM = 1'b0,
    TGT_CFG = 1'b1
  } target_e;

endpackage

// File: clock_ctrl.sv
// Clock control registering fetch enable and gating the core clock with a latch-based cell
module clock_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic fetch_enable_i,
  input  logic test_mode_i,
  output logic clk_en_o,
  output logic clk_o
);

  // Enable as seen by the gate, stable while clk_i is high
  logic en_latched;

  // Fetch enable takes effect one edge later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clk_en_o <= 1'b0;
    end else begin
      clk_en_o <= fetch_enable_i;
    end
  end

  // Transparent during the low phase of clk_i
  always_latch begin
    if (!clk_i) begin
      en_latched = clk_en_o | test_mode_i;
    end
  end

  // Latch output only changes while clk_i is low, so no glitches
  assign clk_o = clk_i & en_latched;

endmodule

// File: data_bus_demux.sv
// Data bus demux routing one transaction at a time to memory or the accelerator config port
module data_bus_demux #(
  parameter complex_pkg::addr_t CfgStart = complex_pkg::DefCfgStart,
  parameter complex_pkg::addr_t CfgEnd   = complex_pkg::DefCfgEnd
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Core side
  input  logic               req_i,
  input  logic               we_i,
  input  complex_pkg::be_t   be_i,
  input  complex_pkg::addr_t addr_i,
  input  complex_pkg::data_t wdata_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output complex_pkg::data_t rdata_o,
  // Memory side
  output logic               mem_req_o,
  output logic               mem_we_o,
  output complex_pkg::be_t   mem_be_o,
  output complex_pkg::addr_t mem_addr_o,
  output complex_pkg::data_t mem_wdata_o,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i,
  input  complex_pkg::data_t mem_rdata_i,
  // Accelerator config side
  output logic               cfg_req_o,
  output logic               cfg_we_o,
  output complex_pkg::be_t   cfg_be_o,
  output complex_pkg::addr_t cfg_addr_o,
  output complex_pkg::data_t cfg_wdata_o,
  input  logic               cfg_gnt_i,
  input  logic               cfg_rvalid_i,
  input  complex_pkg::data_t cfg_rdata_i
);

  import complex_pkg::*;

  localparam int unsigned NumRules = 3;

  // Address map, end bounds exclusive
  localparam addr_t   RuleStart [NumRules] = '{32'h0000_0000, CfgStart, CfgEnd};
  localparam addr_t   RuleEnd   [NumRules] = '{CfgStart, CfgEnd, 32'hFFFF_FFFF};
  localparam target_e RuleTgt   [NumRules] = '{TGT_MEM, TGT_CFG, TGT_MEM};

  target_e dec_sel;
  logic    dec_hit;

  // One transaction in flight and the target it went to
  logic    busy_q;
  target_e tgt_q;

  logic accept;

  // First matching rule wins, no match falls back to memory
  always_comb begin
    dec_sel = TGT_MEM;
    dec_hit = 1'b0;
    for (int i = 0; i < NumRules; i++) begin
      if (!dec_hit && (addr_i >= RuleStart[i]) && (addr_i < RuleEnd[i])) begin
        dec_sel = RuleTgt[i];
        dec_hit = 1'b1;
      end
    end
  end

  // Requests held back while a response is pending
  assign mem_req_o = req_i & ~busy_q & (dec_sel == TGT_MEM);
  assign cfg_req_o = req_i & ~busy_q & (dec_sel == TGT_CFG);

  // Request fields go to both ports, only req qualifies them
  assign mem_we_o    = we_i;
  assign mem_be_o    = be_i;
  assign mem_addr_o  = addr_i;
  assign mem_wdata_o = wdata_i;

  assign cfg_we_o    = we_i;
  assign cfg_be_o    = be_i;
  assign cfg_addr_o  = addr_i;
  assign cfg_wdata_o = wdata_i;

  // Grant from the addressed target
  always_comb begin
    if (dec_sel == TGT_CFG) begin
      gnt_o = req_i & ~busy_q & cfg_gnt_i;
    end else begin
      gnt_o = req_i & ~busy_q & mem_gnt_i;
    end
  end

  assign accept = req_i & gnt_o;

  // Response from the target recorded at grant
  always_comb begin
    if (tgt_q == TGT_CFG) begin
      rvalid_o = busy_q & cfg_rvalid_i;
      rdata_o  = cfg_rdata_i;
    end else begin
      rvalid_o = busy_q & mem_rvalid_i;
      rdata_o  = mem_rdata_i;
    end
  end

  // Set on grant, clear on the matching rvalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      tgt_q  <= TGT_MEM;
    end else if (accept) begin
      busy_q <= 1'b1;
      tgt_q  <= dec_sel;
    end else if (rvalid_o) begin
      busy_q <= 1'b0;
    end
  end

endmodule

// File: accel_complex.sv
// Accelerator complex glue with core clock control and data bus split to memory and config port
module accel_complex #(
  parameter complex_pkg::addr_t CfgStart = complex_pkg::DefCfgStart,
  parameter complex_pkg::addr_t CfgEnd   = complex_pkg::DefCfgEnd
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               test_mode_i,
  input  logic               fetch_enable_i,
  output logic               core_clk_o,
  output logic               core_clk_en_o,
  // Core data bus
  input  logic               core_req_i,
  input  logic               core_we_i,
  input  complex_pkg::be_t   core_be_i,
  input  complex_pkg::addr_t core_addr_i,
  input  complex_pkg::data_t core_wdata_i,
  output logic               core_gnt_o,
  output logic               core_rvalid_o,
  output complex_pkg::data_t core_rdata_o,
  // External memory
  output logic               mem_req_o,
  output logic               mem_we_o,
  output complex_pkg::be_t   mem_be_o,
  output complex_pkg::addr_t mem_addr_o,
  output complex_pkg::data_t mem_wdata_o,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i,
  input  complex_pkg::data_t mem_rdata_i,
  // Accelerator peripheral port
  output logic               periph_req_o,
  output complex_pkg::addr_t periph_add_o,
  output logic               periph_wen_o,
  output complex_pkg::be_t   periph_be_o,
  output complex_pkg::data_t periph_data_o,
  output complex_pkg::id_t   periph_id_o,
  input  logic               periph_gnt_i,
  input  complex_pkg::data_t periph_r_data_i,
  input  logic               periph_r_valid_i
);

  import complex_pkg::*;

  // Single requester, so the id is constant
  localparam id_t PeriphId = '0;

  logic cfg_we;

  clock_ctrl i_clock_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .test_mode_i    ( test_mode_i    ),
    .clk_en_o       ( core_clk_en_o  ),
    .clk_o          ( core_clk_o     )
  );

  // Runs on the free clock so responses land while the core clock is off
  data_bus_demux #(
    .CfgStart ( CfgStart ),
    .CfgEnd   ( CfgEnd   )
  ) i_data_bus_demux (
    .clk_i        ( clk_i            ),
    .rst_ni       ( rst_ni           ),
    .req_i        ( core_req_i       ),
    .we_i         ( core_we_i        ),
    .be_i         ( core_be_i        ),
    .addr_i       ( core_addr_i      ),
    .wdata_i      ( core_wdata_i     ),
    .gnt_o        ( core_gnt_o       ),
    .rvalid_o     ( core_rvalid_o    ),
    .rdata_o      ( core_rdata_o     ),
    .mem_req_o    ( mem_req_o        ),
    .mem_we_o     ( mem_we_o         ),
    .mem_be_o     ( mem_be_o         ),
    .mem_addr_o   ( mem_addr_o       ),
    .mem_wdata_o  ( mem_wdata_o      ),
    .mem_gnt_i    ( mem_gnt_i        ),
    .mem_rvalid_i ( mem_rvalid_i     ),
    .mem_rdata_i  ( mem_rdata_i      ),
    .cfg_req_o    ( periph_req_o     ),
    .cfg_we_o     ( cfg_we           ),
    .cfg_be_o     ( periph_be_o      ),
    .cfg_addr_o   ( periph_add_o     ),
    .cfg_wdata_o  ( periph_data_o    ),
    .cfg_gnt_i    ( periph_gnt_i     ),
    .cfg_rvalid_i ( periph_r_valid_i ),
    .cfg_rdata_i  ( periph_r_data_i  )
  );

  // Peripheral port write enable is active low
  assign periph_wen_o = ~cfg_we;
  assign periph_id_o  = PeriphId;

endmodule

// File: tb_tasks.svh
// Drive, compare and directed test tasks for the accelerator complex testbench
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic abort_run();
  $display("Test failed");
  $fatal(1, "Simulation stopped");
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_addr(input string name, input addr_t exp, input addr_t act);
  if (act !== exp) begin
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_data(input string name, input data_t exp, input data_t act);
  if (act !== exp) begin
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_be(input string name, input be_t exp, input be_t act);
  if (act !== exp) begin
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_id(input string name, input id_t exp, input id_t act);
  if (act !== exp) begin
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    abort_run();
  end
endtask

// Memory below and above the window, config inside it
function automatic logic in_window(input addr_t a);
  if (a < DefCfgStart) begin
    return 1'b0;
  end else if (a < DefCfgEnd) begin
    return 1'b1;
  end
  return 1'b0;
endfunction

function automatic data_t expected_rdata(input addr_t a);
  return a ^ (in_window(a) ? CfgKey : MemKey);
endfunction

task automatic check_routing();
  logic exp_cfg;
  exp_cfg = in_window(core_addr_i);
  check_bit("mem_req_o", !exp_cfg, mem_req_o);
  check_bit("periph_req_o", exp_cfg, periph_req_o);
  if (exp_cfg) begin
    check_addr("periph_add_o", core_addr_i, periph_add_o);
    check_be("periph_be_o", core_be_i, periph_be_o);
    check_data("periph_data_o", core_wdata_i, periph_data_o);
    check_bit("periph_wen_o", !core_we_i, periph_wen_o);
    check_id("periph_id_o", '0, periph_id_o);
  end else begin
    check_bit("mem_we_o", core_we_i, mem_we_o);
    check_be("mem_be_o", core_be_i, mem_be_o);
    check_addr("mem_addr_o", core_addr_i, mem_addr_o);
    check_data("mem_wdata_o", core_wdata_i, mem_wdata_o);
  end
endtask

// Called 2 ns after a rising edge
task automatic issue_req(input logic we, input be_t be, input addr_t addr, input data_t wdata);
  core_req_i   = 1'b1;
  core_we_i    = we;
  core_be_i    = be;
  core_addr_i  = addr;
  core_wdata_i = wdata;
endtask

task automatic wait_grant();
  @(negedge clk_i);
  while (!core_gnt_o) begin
    @(negedge clk_i);
  end
  check_routing();
endtask

task automatic release_req();
  @(posedge clk_i);
  #2;
  core_req_i = 1'b0;
endtask

// Returns aligned 2 ns after a rising edge
task automatic wait_response(output data_t rdata);
  @(negedge clk_i);
  while (!core_rvalid_o) begin
    @(negedge clk_i);
  end
  rdata = core_rdata_o;
  @(posedge clk_i);
  #2;
endtask

task automatic bus_access(input logic we, input be_t be, input addr_t addr, input data_t wdata);
  data_t rdata;
  issue_req(we, be, addr, wdata);
  wait_grant();
  release_req();
  wait_response(rdata);
  check_data("core_rdata_o", expected_rdata(addr), rdata);
endtask

task automatic check_reset_outputs();
  check_bit("core_clk_en_o", 1'b0, core_clk_en_o);
  check_bit("core_gnt_o", 1'b0, core_gnt_o);
  check_bit("core_rvalid_o", 1'b0, core_rvalid_o);
  check_bit("mem_req_o", 1'b0, mem_req_o);
  check_bit("periph_req_o", 1'b0, periph_req_o);
endtask

task automatic test_reset();
  @(posedge clk_i);
  #2;
  check_reset_outputs();
  // Enable held high so only the reset keeps the clock enable low
  fetch_enable_i = 1'b1;
  repeat (2) begin
    @(posedge clk_i);
    #2;
    check_reset_outputs();
  end
  rst_ni         = 1'b1;
  fetch_enable_i = 1'b0;
  @(negedge clk_i);
  check_reset_outputs();
  @(posedge clk_i);
  #2;
endtask

task automatic test_clock_gating();
  fetch_enable_i = 1'b1;
  @(negedge clk_i);
  check_bit("core_clk_en_o", 1'b0, core_clk_en_o);
  @(negedge clk_i);
  check_bit("core_clk_en_o", 1'b1, core_clk_en_o);
  @(posedge clk_i);
  #5;
  check_bit("core_clk_o", 1'b1, core_clk_o);
  @(negedge clk_i);
  #5;
  check_bit("core_clk_o", 1'b0, core_clk_o);
  @(posedge clk_i);
  #2;
  fetch_enable_i = 1'b0;
  @(negedge clk_i);
  check_bit("core_clk_en_o", 1'b1, core_clk_en_o);
  @(negedge clk_i);
  check_bit("core_clk_en_o", 1'b0, core_clk_en_o);
  // No high phase gets through while gated off
  repeat (4) begin
    @(posedge clk_i);
    #5;
    check_bit("core_clk_o", 1'b0, core_clk_o);
  end
  @(posedge clk_i);
  #2;
  test_mode_i = 1'b1;
  @(posedge clk_i);
  #5;
  check_bit("core_clk_o", 1'b1, core_clk_o);
  @(negedge clk_i);
  #5;
  check_bit("core_clk_o", 1'b0, core_clk_o);
  @(posedge clk_i);
  #2;
  test_mode_i    = 1'b0;
  fetch_enable_i = 1'b1;
endtask

task automatic test_mem_routing();
  mem_gnt_dly = 1;
  mem_rv_dly  = 1;
  bus_access(1'b1, 4'hf, 32'h0000_1000, 32'hdead_beef);
  bus_access(1'b0, 4'hf, 32'h0000_1000, 32'h0);
  bus_access(1'b1, 4'h3, 32'h000f_fffc, 32'h1234_5678);
  bus_access(1'b0, 4'hc, 32'h0010_0400, 32'h0);
  bus_access(1'b1, 4'h1, 32'hffff_fff0, 32'hcafe_f00d);
endtask

task automatic test_cfg_routing();
  cfg_gnt_dly = 0;
  cfg_rv_dly  = 2;
  bus_access(1'b1, 4'hf, 32'h0010_0000, 32'h0bad_cafe);
  bus_access(1'b0, 4'hf, 32'h0010_0000, 32'h0);
  bus_access(1'b1, 4'h6, 32'h0010_0200, 32'h5555_aaaa);
  bus_access(1'b0, 4'h8, 32'h0010_03fc, 32'h0);
endtask

// Second request waits until the first response arrives
task automatic in_flight_pair(input addr_t addr_a, input addr_t addr_b);
  data_t rdata;
  issue_req(1'b0, 4'hf, addr_a, 32'h0);
  wait_grant();
  @(posedge clk_i);
  #2;
  issue_req(1'b1, 4'h5, addr_b, 32'h7777_1111);
  @(negedge clk_i);
  while (!core_rvalid_o) begin
    check_bit("core_gnt_o", 1'b0, core_gnt_o);
    check_bit("mem_req_o", 1'b0, mem_req_o);
    check_bit("periph_req_o", 1'b0, periph_req_o);
    @(negedge clk_i);
  end
  check_bit("core_gnt_o", 1'b0, core_gnt_o);
  check_data("core_rdata_o", expected_rdata(addr_a), core_rdata_o);
  wait_grant();
  release_req();
  wait_response(rdata);
  check_data("core_rdata_o", expected_rdata(addr_b), rdata);
endtask

task automatic test_in_flight();
  mem_gnt_dly = 0;
  mem_rv_dly  = 5;
  cfg_gnt_dly = 1;
  cfg_rv_dly  = 4;
  in_flight_pair(32'h0000_2000, 32'h0010_0010);
  in_flight_pair(32'h0010_0020, 32'h0020_0000);
  in_flight_pair(32'h0000_3000, 32'h0000_3004);
endtask

task automatic test_random_sweep();
  logic [31:0] bits;
  addr_t       edge_addr;
  addr_t       addr;
  int          offset;
  for (int i = 0; i < 20; i++) begin
    bits        = $random(seed);
    mem_gnt_dly = int'(bits[9:8]) % 3;
    mem_rv_dly  = int'(bits[11:10]) % 3;
    cfg_gnt_dly = int'(bits[13:12]) % 3;
    cfg_rv_dly  = int'(bits[15:14]) % 3;
    edge_addr   = bits[5] ? DefCfgEnd : DefCfgStart;
    offset      = $random(seed) % 16;
    if (bits[7:6] == 2'b00) begin
      addr = $random(seed);
    end else begin
      addr = edge_addr + addr_t'(offset * 4);
    end
    bus_access(bits[0], bits[4:1], addr, $random(seed));
  end
endtask

`endif

// File: tb_accel_complex.sv
// Testbench for the accelerator complex with bus responders, watchdog and directed tests
module tb_accel_complex;

  timeunit 1ns;
  timeprecision 1ps;

  import complex_pkg::*;

  localparam int ClkPeriod = 40;
  localparam int NumTests  = 6;

  // Read data keys, each target returns address XOR its key
  localparam data_t MemKey = 32'h5a5a_c3c3;
  localparam data_t CfgKey = 32'h0f1e_2d3c;

  logic  clk_i;
  logic  rst_ni;
  logic  test_mode_i;
  logic  fetch_enable_i;
  logic  core_clk_o;
  logic  core_clk_en_o;

  logic  core_req_i;
  logic  core_we_i;
  be_t   core_be_i;
  addr_t core_addr_i;
  data_t core_wdata_i;
  logic  core_gnt_o;
  logic  core_rvalid_o;
  data_t core_rdata_o;

  logic  mem_req_o;
  logic  mem_we_o;
  be_t   mem_be_o;
  addr_t mem_addr_o;
  data_t mem_wdata_o;
  logic  mem_gnt_i;
  logic  mem_rvalid_i;
  data_t mem_rdata_i;

  logic  periph_req_o;
  addr_t periph_add_o;
  logic  periph_wen_o;
  be_t   periph_be_o;
  data_t periph_data_o;
  id_t   periph_id_o;
  logic  periph_gnt_i;
  data_t periph_r_data_i;
  logic  periph_r_valid_i;

  // Responder latencies in cycles, changed by the tests
  int mem_gnt_dly;
  int mem_rv_dly;
  int cfg_gnt_dly;
  int cfg_rv_dly;

  integer seed;

  `include "tb_tasks.svh"

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  accel_complex dut (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .test_mode_i      ( test_mode_i      ),
    .fetch_enable_i   ( fetch_enable_i   ),
    .core_clk_o       ( core_clk_o       ),
    .core_clk_en_o    ( core_clk_en_o    ),
    .core_req_i       ( core_req_i       ),
    .core_we_i        ( core_we_i        ),
    .core_be_i        ( core_be_i        ),
    .core_addr_i      ( core_addr_i      ),
    .core_wdata_i     ( core_wdata_i     ),
    .core_gnt_o       ( core_gnt_o       ),
    .core_rvalid_o    ( core_rvalid_o    ),
    .core_rdata_o     ( core_rdata_o     ),
    .mem_req_o        ( mem_req_o        ),
    .mem_we_o         ( mem_we_o         ),
    .mem_be_o         ( mem_be_o         ),
    .mem_addr_o       ( mem_addr_o       ),
    .mem_wdata_o      ( mem_wdata_o      ),
    .mem_gnt_i        ( mem_gnt_i        ),
    .mem_rvalid_i     ( mem_rvalid_i     ),
    .mem_rdata_i      ( mem_rdata_i      ),
    .periph_req_o     ( periph_req_o     ),
    .periph_add_o     ( periph_add_o     ),
    .periph_wen_o     ( periph_wen_o     ),
    .periph_be_o      ( periph_be_o      ),
    .periph_data_o    ( periph_data_o    ),
    .periph_id_o      ( periph_id_o      ),
    .periph_gnt_i     ( periph_gnt_i     ),
    .periph_r_data_i  ( periph_r_data_i  ),
    .periph_r_valid_i ( periph_r_valid_i )
  );

  bus_responder #(.Key(MemKey)) i_mem_responder (
    .clk_i     ( clk_i       ),
    .req_i     ( mem_req_o   ),
    .addr_i    ( mem_addr_o  ),
    .gnt_dly_i ( mem_gnt_dly ),
    .rv_dly_i  ( mem_rv_dly  ),
    .gnt_o     ( mem_gnt_i   ),
    .rvalid_o  ( mem_rvalid_i ),
    .rdata_o   ( mem_rdata_i )
  );

  bus_responder #(.Key(CfgKey)) i_cfg_responder (
    .clk_i     ( clk_i            ),
    .req_i     ( periph_req_o     ),
    .addr_i    ( periph_add_o     ),
    .gnt_dly_i ( cfg_gnt_dly      ),
    .rv_dly_i  ( cfg_rv_dly       ),
    .gnt_o     ( periph_gnt_i     ),
    .rvalid_o  ( periph_r_valid_i ),
    .rdata_o   ( periph_r_data_i  )
  );

  initial begin : watchdog
    #(NumTests * 200 * ClkPeriod);
    $display("Timeout: the tests did not finish within %0d cycles", NumTests * 200);
    abort_run();
  end

  initial begin : test_sequence
    rst_ni         = 1'b0;
    test_mode_i    = 1'b0;
    fetch_enable_i = 1'b0;
    core_req_i     = 1'b0;
    core_we_i      = 1'b0;
    core_be_i      = '0;
    core_addr_i    = '0;
    core_wdata_i   = '0;
    mem_gnt_dly    = 0;
    mem_rv_dly     = 0;
    cfg_gnt_dly    = 0;
    cfg_rv_dly     = 0;
    seed           = 32'h4e96;

    test_reset();
    test_clock_gating();
    test_mem_routing();
    test_cfg_routing();
    test_in_flight();
    test_random_sweep();

    $display("Test completed successfully");
    $finish;
  end

endmodule

// Target model that grants and answers one request after programmable delays
module bus_responder #(
  parameter complex_pkg::data_t Key = '0
) (
  input  logic               clk_i,
  input  logic               req_i,
  input  complex_pkg::addr_t addr_i,
  input  int                 gnt_dly_i,
  input  int                 rv_dly_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output complex_pkg::data_t rdata_o
);

  timeunit 1ns;
  timeprecision 1ps;

  complex_pkg::addr_t addr_q;

  // Samples at the falling edge, drives 2 ns after the rising edge
  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    forever begin
      @(negedge clk_i);
      if (req_i) begin
        repeat (gnt_dly_i) @(posedge clk_i);
        @(posedge clk_i);
        #2;
        gnt_o = 1'b1;
        @(negedge clk_i);
        addr_q = addr_i;
        @(posedge clk_i);
        #2;
        gnt_o = 1'b0;
        repeat (rv_dly_i) begin
          @(posedge clk_i);
          #2;
        end
        rvalid_o = 1'b1;
        rdata_o  = addr_q ^ Key;
        @(posedge clk_i);
        #2;
        rvalid_o = 1'b0;
        rdata_o  = '0;
      end
    end
  end

endmodule

// File: files.f
complex_pkg.sv
clock_ctrl.sv
data_bus_demux.sv
accel_complex.sv
+incdir+.
tb_accel_complex.sv

// File: Makefile
# Verilator build and run for the accelerator complex testbench

TOP = tb_accel_complex
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary -j 0 -f files.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)
	verilator --lint-only -f files.f complex_pkg.sv --top-module accel_complex

clean:
	rm -rf obj_dir $(LOG)
